/* flist.f */
src/cpuPkg.sv
src/controlUnit.sv
src/alu.sv
src/registerFile.sv
src/fetchUnit.sv
src/processor.sv
sim/processor_asserts.sv
sim/tbProcessor.sv

/* sim/processor_asserts.sv */
`timescale 1ns/1ps

module processorAsserts (
	input logic clk,
	input logic rst,
	input logic [cpuPkg::dataWidth-1:0] instrAddr,
	input logic memWe,
	input logic memRe,
	input logic halted
);

	int failCount = 0; // assertion failures seen so far

	// one data memory strobe per cycle
	strobeExclusive: assert property (@(posedge clk) !(memWe && memRe))
		else begin
			$error("memWe and memRe high in the same cycle");
			failCount++;
		end

	// halt latch is sticky and the fetch address freezes
	haltHolds: assert property (@(posedge clk) disable iff (!rst)
		halted |=> (halted && $stable(instrAddr)))
		else begin
			$error("halted dropped or instrAddr moved after halt");
			failCount++;
		end

	// control word is cleared while reset is low
	noStoreInReset: assert property (@(posedge clk) !rst |-> !memWe)
		else begin
			$error("memWe high during reset");
			failCount++;
		end

endmodule

bind processor processorAsserts asserts0 (
	.clk(clk),
	.rst(rst),
	.instrAddr(instrAddr),
	.memWe(memWe),
	.memRe(memRe),
	.halted(halted)
);

/* sim/tbProcessor.sv */
`timescale 1ns/1ps

module tbProcessor;

	localparam int runLimit = 64; // cycles allowed per program
	localparam int timeoutLimit = 6 * runLimit + 16; // whole run

	logic clk = 1'b0;
	logic rst = 1'b0;
	logic [31:0] instrAddr, instr, memAddr, memWdata, memRdata;
	logic memWe, memRe, halted;

	logic [31:0] imem [64]; // instruction memory model
	logic [31:0] dmem [64]; // data memory model
	int storeCount = 0;
	int progLen = 0; // next free instruction slot
	int errors = 0;
	int cycleCount = 0;

	processor dut0 (.clk(clk), .rst(rst), .instrAddr(instrAddr), .instr(instr),
		.memAddr(memAddr), .memWdata(memWdata), .memWe(memWe), .memRe(memRe),
		.memRdata(memRdata), .halted(halted));

	always #4 clk = ~clk; // 8 ns period

	assign instr = imem[instrAddr[7:2]]; // combinational fetch
	assign memRdata = memRe ? dmem[memAddr[7:2]] : '0; // bus idles at zero without the strobe

	always @(posedge clk) begin
		if (memWe) begin
			dmem[memAddr[7:2]] <= memWdata; // store lands at the edge
			storeCount <= storeCount + 1;
		end
	end

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= timeoutLimit) begin
			errors++;
			$display("timeout: run did not finish within %0d cycles", timeoutLimit);
			$display("errors: %0d, assertion failures: %0d", errors,
				dut0.asserts0.failCount);
			$display("Some tests failed");
			$finish;
		end
	end

	function automatic logic [31:0] encR(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
			logic [5:0] fn);
		return {6'd0, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] encI(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
			logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] dataFill(int i);
		return 32'hd0000000 | (i << 8) | i; // word index shows in two bytes
	endfunction

	function automatic logic [31:0] sext(logic [15:0] imm);
		return {{16{imm[15]}}, imm};
	endfunction

	function automatic logic [31:0] signedLess(logic [31:0] x, logic [31:0] y);
		logic [32:0] diff;
		diff = {x[31], x} - {y[31], y}; // 33 bit difference never overflows
		return {31'd0, diff[32]};
	endfunction

	task automatic checkValue(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic emit(logic [31:0] word);
		imem[progLen] = word;
		progLen++;
	endtask

	task automatic assertReset();
		@(posedge clk);
		#1 rst = 1'b0;
		for (int i = 0; i < 64; i++) begin
			imem[i] = encI(cpuPkg::opHlt, 5'd0, 5'd0, 16'(i)); // stray fetches halt
			dmem[i] = dataFill(i);
		end
		storeCount = 0;
		progLen = 0;
	endtask

	task automatic releaseReset();
		repeat (2) @(posedge clk);
		#1 rst = 1'b1;
	endtask

	task automatic runUntilHalted();
		int cycles;
		cycles = 0;
		while (!halted && cycles < runLimit) begin
			@(posedge clk);
			#1 cycles++;
		end
		if (!halted) begin
			errors++;
			$display("program did not halt within %0d cycles", runLimit);
		end
	endtask

	task automatic testReset();
		assertReset();
		emit(encI(cpuPkg::opSw, 5'd0, 5'd0, 16'd0)); // store that reset has to mask
		@(posedge clk);
		#1 checkValue("instrAddr", instrAddr, 32'd0); // inside reset
		checkValue("halted", 32'(halted), 32'd0);
		checkValue("memWe", 32'(memWe), 32'd0);
		imem[0] = encI(cpuPkg::opHlt, 5'd0, 5'd0, 16'd0); // program is a single hlt
		@(posedge clk);
		#1 rst = 1'b1;
		checkValue("instrAddr", instrAddr, 32'd0); // first cycle after reset
		checkValue("halted", 32'(halted), 32'd0);
		checkValue("memWe", 32'(memWe), 32'd0);
		runUntilHalted();
		checkValue("storeCount", 32'(storeCount), 32'd0);
	endtask

	task automatic testArith();
		logic [15:0] immA, immB;
		logic [31:0] a, b;
		immA = 16'($urandom);
		immB = 16'($urandom) | 16'h8000; // b is always negative
		a = sext(immA);
		b = sext(immB);
		assertReset();
		emit(encI(cpuPkg::opAddi, 5'd0, 5'd1, immA));
		emit(encI(cpuPkg::opAddi, 5'd0, 5'd2, immB));
		emit(encR(5'd1, 5'd2, 5'd3, cpuPkg::fnAdd));
		emit(encR(5'd1, 5'd2, 5'd4, cpuPkg::fnSub));
		emit(encR(5'd1, 5'd2, 5'd5, cpuPkg::fnAnd));
		emit(encR(5'd1, 5'd2, 5'd6, cpuPkg::fnOr));
		emit(encR(5'd1, 5'd2, 5'd7, cpuPkg::fnSlt));
		emit(encR(5'd2, 5'd1, 5'd8, cpuPkg::fnSlt)); // negative on the left
		for (int r = 3; r <= 8; r++) begin
			emit(encI(cpuPkg::opSw, 5'd0, 5'(r), 16'((r - 3) * 4)));
		end
		emit(encI(cpuPkg::opHlt, 5'd0, 5'd0, 16'd0));
		releaseReset();
		runUntilHalted();
		checkValue("dmem[0] add", dmem[0], a + b);
		checkValue("dmem[1] sub", dmem[1], a - b);
		checkValue("dmem[2] and", dmem[2], a & b);
		checkValue("dmem[3] or", dmem[3], a | b);
		checkValue("dmem[4] slt", dmem[4], signedLess(a, b));
		checkValue("dmem[5] slt", dmem[5], signedLess(b, a));
	endtask

	task automatic testLoadStore();
		logic [31:0] x, y;
		x = $urandom;
		y = $urandom;
		assertReset();
		dmem[8] = x;
		dmem[9] = y;
		emit(encI(cpuPkg::opLw, 5'd0, 5'd1, 16'd32));
		emit(encI(cpuPkg::opLw, 5'd0, 5'd2, 16'd36));
		emit(encR(5'd1, 5'd2, 5'd3, cpuPkg::fnAdd));
		emit(encI(cpuPkg::opSw, 5'd0, 5'd3, 16'd40));
		emit(encI(cpuPkg::opHlt, 5'd0, 5'd0, 16'd0));
		releaseReset();
		runUntilHalted();
		checkValue("dmem[10] sum", dmem[10], x + y);
		checkValue("dmem[8]", dmem[8], x); // sources untouched
		checkValue("dmem[9]", dmem[9], y);
	endtask

	task automatic testBranch();
		assertReset();
		emit(encI(cpuPkg::opAddi, 5'd0, 5'd1, 16'd5));
		emit(encI(cpuPkg::opAddi, 5'd0, 5'd2, 16'd5));
		emit(encI(cpuPkg::opAddi, 5'd0, 5'd3, 16'd7));
		emit(encI(cpuPkg::opBeq, 5'd1, 5'd2, 16'd1)); // equal registers skip the next store
		emit(encI(cpuPkg::opSw, 5'd0, 5'd1, 16'd0));
		emit(encI(cpuPkg::opSw, 5'd0, 5'd3, 16'd4));
		emit(encI(cpuPkg::opBeq, 5'd1, 5'd3, 16'd1)); // unequal registers fall through
		emit(encI(cpuPkg::opSw, 5'd0, 5'd2, 16'd8));
		emit(encI(cpuPkg::opHlt, 5'd0, 5'd0, 16'd0));
		releaseReset();
		runUntilHalted();
		checkValue("dmem[0]", dmem[0], dataFill(0)); // skipped store
		checkValue("dmem[1]", dmem[1], 32'd7);
		checkValue("dmem[2]", dmem[2], 32'd5);
		checkValue("storeCount", 32'(storeCount), 32'd2);
	endtask

	task automatic testInvalid();
		assertReset();
		emit(encI(cpuPkg::opAddi, 5'd0, 5'd1, 16'h1234));
		emit(encI(cpuPkg::opAddi, 5'd0, 5'd2, 16'h0055));
		emit(encR(5'd1, 5'd2, 5'd1, 6'h3f)); // unknown funct aimed at r1
		emit(encI(6'd13, 5'd1, 5'd2, 16'h00ff)); // unknown opcode aimed at r2
		emit(encI(cpuPkg::opAddi, 5'd0, 5'd0, 16'h0777)); // r0 stays zero
		emit(encI(cpuPkg::opSw, 5'd0, 5'd1, 16'd0));
		emit(encI(cpuPkg::opSw, 5'd0, 5'd2, 16'd4));
		emit(encI(cpuPkg::opSw, 5'd0, 5'd0, 16'd8));
		emit(encI(cpuPkg::opHlt, 5'd0, 5'd0, 16'd0));
		releaseReset();
		runUntilHalted();
		checkValue("dmem[0] r1", dmem[0], 32'h1234);
		checkValue("dmem[1] r2", dmem[1], 32'h0055);
		checkValue("dmem[2] r0", dmem[2], 32'd0);
	endtask

	task automatic testHalt();
		int countAtHalt;
		assertReset();
		emit(encI(cpuPkg::opAddi, 5'd0, 5'd1, 16'd9));
		emit(encI(cpuPkg::opSw, 5'd0, 5'd1, 16'd0));
		emit(encI(cpuPkg::opHlt, 5'd0, 5'd0, 16'd0)); // at byte address 8
		emit(encI(cpuPkg::opSw, 5'd0, 5'd1, 16'd4)); // must never run
		releaseReset();
		runUntilHalted();
		countAtHalt = storeCount;
		repeat (10) begin
			@(posedge clk);
			#1 checkValue("halted", 32'(halted), 32'd1);
			checkValue("instrAddr", instrAddr, 32'd8);
			checkValue("storeCount", 32'(storeCount), 32'(countAtHalt));
		end
		checkValue("dmem[1]", dmem[1], dataFill(1));
	endtask

	initial begin
		void'($urandom(32'h270d7062)); // single seed for the run
		for (int i = 0; i < 64; i++) begin
			imem[i] = encI(cpuPkg::opHlt, 5'd0, 5'd0, 16'(i));
			dmem[i] = dataFill(i);
		end
		testReset();
		testArith();
		testLoadStore();
		testBranch();
		testInvalid();
		testHalt();
		$display("errors: %0d, assertion failures: %0d", errors, dut0.asserts0.failCount);
		if (errors == 0 && dut0.asserts0.failCount == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

/* src/alu.sv */
`timescale 1ns/1ps

module alu (
	input logic [cpuPkg::dataWidth-1:0] a,
	input logic [cpuPkg::dataWidth-1:0] b,
	input cpuPkg::aluOpE aluOp,
	output logic [cpuPkg::dataWidth-1:0] result,
	output logic zero
);

	always_comb begin
		case (aluOp)
			cpuPkg::aluAdd: begin
				result = a + b; // wraps on overflow
			end
			cpuPkg::aluSub: begin
				result = a - b;
			end
			cpuPkg::aluAnd: begin
				result = a & b;
			end
			cpuPkg::aluOr: begin
				result = a | b;
			end
			cpuPkg::aluSlt: begin
				// two's complement compare, only bit 0 can be set
				result = ($signed(a) < $signed(b)) ? {{(cpuPkg::dataWidth-1){1'b0}}, 1'b1}
					: '0;
			end
			default: begin
				result = '0; // unused op codes
			end
		endcase
	end

	assign zero = (result == '0); // used by beq after the subtract

endmodule

/* src/controlUnit.sv */
`timescale 1ns/1ps

module controlUnit (
	input cpuPkg::opCodeE opCode,
	input cpuPkg::functE funct,
	input logic rst,
	output cpuPkg::ctrlT ctrl
);

	always_comb begin
		ctrl = '0; // every field low, aluOp reads as add

		if (rst) begin // active low reset keeps the word cleared
			case (opCode)
				cpuPkg::opHlt: begin
					ctrl.hlt = 1'b1; // freezes the pc in fetchUnit
				end

				cpuPkg::opRType: begin
					ctrl.regDst = 1'b1; // destination is rd
					ctrl.regWriteEn = 1'b1; // result goes back to rd
					ctrl.aluSrc = 1'b0; // both operands from registers
					case (funct)
						cpuPkg::fnAdd: ctrl.aluOp = cpuPkg::aluAdd;
						cpuPkg::fnSub: ctrl.aluOp = cpuPkg::aluSub;
						cpuPkg::fnAnd: ctrl.aluOp = cpuPkg::aluAnd;
						cpuPkg::fnOr: ctrl.aluOp = cpuPkg::aluOr;
						cpuPkg::fnSlt: ctrl.aluOp = cpuPkg::aluSlt;
						default: ctrl.regWriteEn = 1'b0; // bad funct, register file untouched
					endcase
				end

				cpuPkg::opAddi: begin
					ctrl.regDst = 1'b0; // destination is rt
					ctrl.aluOp = cpuPkg::aluAdd;
					ctrl.regWriteEn = 1'b1;
					ctrl.aluSrc = 1'b1; // rs plus immediate
				end

				cpuPkg::opLw: begin
					ctrl.regDst = 1'b0; // loaded word lands in rt
					ctrl.memReadEn = 1'b1;
					ctrl.memToReg = 1'b1; // write back the memory word
					ctrl.aluOp = cpuPkg::aluAdd; // address is base plus offset
					ctrl.regWriteEn = 1'b1;
					ctrl.aluSrc = 1'b1;
				end

				cpuPkg::opSw: begin
					ctrl.aluOp = cpuPkg::aluAdd; // address is base plus offset
					ctrl.memWriteEn = 1'b1; // rt value goes to memory
					ctrl.aluSrc = 1'b1;
				end

				cpuPkg::opBeq: begin
					ctrl.aluOp = cpuPkg::aluSub; // zero flag set when rs equals rt
					ctrl.aluSrc = 1'b0; // compare against rt
					ctrl.branch = 1'b1;
				end

				default: ; // unknown opcode behaves as a no-op
			endcase
		end
	end

endmodule

/* src/cpuPkg.sv */
package cpuPkg;

	localparam int dataWidth = 32; // data word and byte address width
	localparam int regAddrWidth = 5; // register index width

	// primary opcode field, instr[31:26]
	typedef enum logic [5:0] {
		opRType = 6'd0, // alu ops selected by funct
		opBeq = 6'd4, // branch on equal
		opAddi = 6'd8, // add immediate
		opLw = 6'd35, // load word
		opSw = 6'd43, // store word
		opHlt = 6'd63 // stop fetching
	} opCodeE;

	// r-type funct field, instr[5:0]
	typedef enum logic [5:0] {
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnOr = 6'h25,
		fnSlt = 6'h2A
	} functE;

	typedef enum logic [2:0] {
		aluAdd = 3'd0,
		aluSub = 3'd1, // also used by beq for the compare
		aluAnd = 3'd2,
		aluOr = 3'd3,
		aluSlt = 3'd4 // signed compare, result is 0 or 1
	} aluOpE;

	typedef struct packed {
		logic regDst; // 1 selects rd, 0 selects rt
		logic memReadEn; // data memory read strobe
		logic memToReg; // write back from memory instead of alu
		aluOpE aluOp; // operation for the alu
		logic memWriteEn; // data memory write strobe
		logic regWriteEn; // register file write enable
		logic aluSrc; // b operand is the sign extended immediate
		logic branch; // beq, next pc may take the target
		logic hlt; // halt instruction
	} ctrlT;

endpackage

/* src/fetchUnit.sv */
`timescale 1ns/1ps

module fetchUnit (
	input logic clk,
	input logic rst,
	input logic branch, // current instruction is beq
	input logic zero, // alu compare result
	input logic hltInstr, // current instruction is hlt
	input logic [cpuPkg::dataWidth-1:0] immExt, // sign extended word offset
	output logic [cpuPkg::dataWidth-1:0] pc,
	output logic halted
);

	logic [cpuPkg::dataWidth-1:0] pcPlus4; // sequential address
	logic [cpuPkg::dataWidth-1:0] branchTarget; // pc+4 plus offset in bytes
	logic [cpuPkg::dataWidth-1:0] pcNext;

	always_comb begin
		pcPlus4 = pc + cpuPkg::dataWidth'(4);
		branchTarget = pcPlus4 + {immExt[cpuPkg::dataWidth-3:0], 2'b00}; // word offset times 4
		if (halted || hltInstr) begin
			pcNext = pc; // hold on the hlt address
		end else if (branch && zero) begin
			pcNext = branchTarget; // taken beq
		end else begin
			pcNext = pcPlus4;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			pc <= '0;
			halted <= 1'b0;
		end else begin
			pc <= pcNext;
			halted <= halted | hltInstr; // sticky until reset
		end
	end

endmodule

/* src/processor.sv */
`timescale 1ns/1ps

module processor (
	input logic clk,
	input logic rst,
	output logic [cpuPkg::dataWidth-1:0] instrAddr, // byte address of the fetch
	input logic [cpuPkg::dataWidth-1:0] instr, // word at instrAddr, same cycle
	output logic [cpuPkg::dataWidth-1:0] memAddr,
	output logic [cpuPkg::dataWidth-1:0] memWdata,
	output logic memWe,
	output logic memRe,
	input logic [cpuPkg::dataWidth-1:0] memRdata, // combinational read data
	output logic halted
);

	cpuPkg::ctrlT ctrl; // decoded control word
	cpuPkg::opCodeE opCode;
	cpuPkg::functE funct;

	logic [cpuPkg::regAddrWidth-1:0] rs; // instruction fields
	logic [cpuPkg::regAddrWidth-1:0] rt;
	logic [cpuPkg::regAddrWidth-1:0] rd;
	logic [15:0] imm;
	logic [cpuPkg::dataWidth-1:0] immExt;

	logic [cpuPkg::regAddrWidth-1:0] writeAddr; // destination register
	logic [cpuPkg::dataWidth-1:0] writeData; // write back value
	logic [cpuPkg::dataWidth-1:0] rsData;
	logic [cpuPkg::dataWidth-1:0] rtData;
	logic [cpuPkg::dataWidth-1:0] aluB; // second alu operand
	logic [cpuPkg::dataWidth-1:0] aluResult;
	logic aluZero;

	// field slicing
	assign opCode = cpuPkg::opCodeE'(instr[31:26]);
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign rd = instr[15:11];
	assign imm = instr[15:0];
	assign funct = cpuPkg::functE'(instr[5:0]);
	assign immExt = {{(cpuPkg::dataWidth-16){imm[15]}}, imm}; // sign extension

	// datapath muxes
	assign writeAddr = ctrl.regDst ? rd : rt; // r-type writes rd, i-type writes rt
	assign aluB = ctrl.aluSrc ? immExt : rtData;
	assign writeData = ctrl.memToReg ? memRdata : aluResult; // lw takes the memory word

	// data memory bus
	assign memAddr = aluResult; // base plus offset
	assign memWdata = rtData; // sw stores rt
	assign memWe = ctrl.memWriteEn;
	assign memRe = ctrl.memReadEn;

	controlUnit ctrl0 (
		.opCode(opCode),
		.funct(funct),
		.rst(rst),
		.ctrl(ctrl)
	);

	registerFile regFile0 (
		.clk(clk),
		.rst(rst),
		.readAddrA(rs),
		.readAddrB(rt),
		.writeAddr(writeAddr),
		.writeEn(ctrl.regWriteEn),
		.writeData(writeData),
		.readDataA(rsData),
		.readDataB(rtData)
	);

	alu alu0 (
		.a(rsData),
		.b(aluB),
		.aluOp(ctrl.aluOp),
		.result(aluResult),
		.zero(aluZero)
	);

	fetchUnit fetch0 (
		.clk(clk),
		.rst(rst),
		.branch(ctrl.branch),
		.zero(aluZero),
		.hltInstr(ctrl.hlt),
		.immExt(immExt),
		.pc(instrAddr), // pc drives the fetch address directly
		.halted(halted)
	);

endmodule

/* src/registerFile.sv */
`timescale 1ns/1ps

module registerFile (
	input logic clk,
	input logic rst,
	input logic [cpuPkg::regAddrWidth-1:0] readAddrA,
	input logic [cpuPkg::regAddrWidth-1:0] readAddrB,
	input logic [cpuPkg::regAddrWidth-1:0] writeAddr,
	input logic writeEn,
	input logic [cpuPkg::dataWidth-1:0] writeData,
	output logic [cpuPkg::dataWidth-1:0] readDataA,
	output logic [cpuPkg::dataWidth-1:0] readDataB
);

	localparam int regCount = 2 ** cpuPkg::regAddrWidth; // 32 entries

	logic [cpuPkg::dataWidth-1:0] regs [regCount]; // register storage

	always_ff @(posedge clk) begin
		if (!rst) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0; // all registers start at zero
			end
		end else if (writeEn && (writeAddr != '0)) begin
			regs[writeAddr] <= writeData; // writes to r0 are dropped
		end
	end

	// combinational reads, r0 hardwired to zero
	always_comb begin
		readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
		readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];
	end

endmodule
